//--- source/ahb_pkg.sv
// shared AHB fabric types, sizes and address map; imported by every fabric module and the testbench
package ahb_pkg;

  // ----------------------------------------------------------------------
  // bus sizes
  // ----------------------------------------------------------------------
  localparam int num_masters = 3;
  localparam int num_slaves  = 3;
  localparam int addr_w      = 32;
  localparam int data_w      = 32;
  localparam int master_id_w = 4;

  // ----------------------------------------------------------------------
  // address map, index 0 is the rightmost word
  // ----------------------------------------------------------------------
  localparam logic [num_slaves-1:0][addr_w-1:0] slave_base = {
    32'h2000_0000,
    32'h1000_0000,
    32'h0000_0000
  };

  localparam logic [num_slaves-1:0][addr_w-1:0] slave_size = {
    32'h0001_0000,
    32'h0001_0000,
    32'h0001_0000
  };

  // ----------------------------------------------------------------------
  // encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    trans_idle   = 2'b00,
    trans_busy   = 2'b01,
    trans_nonseq = 2'b10,
    trans_seq    = 2'b11
  } htrans_e;

  typedef enum logic [1:0] {
    resp_okay  = 2'b00,
    resp_error = 2'b01,
    resp_retry = 2'b10,
    resp_split = 2'b11
  } hresp_e;

  typedef logic [2:0] hsize_t;
  typedef logic [2:0] hburst_t;
  typedef logic [3:0] hprot_t;

  // address phase as seen by the slaves
  typedef struct packed {
    logic [addr_w-1:0] haddr;
    htrans_e           htrans;
    logic              hwrite;
    hsize_t            hsize;
    hburst_t           hburst;
    hprot_t            hprot;
  } ahb_addr_t;

  // slave response toward the masters
  typedef struct packed {
    logic [data_w-1:0] hrdata;
    hresp_e            hresp;
    logic              hready;
  } ahb_resp_t;

  typedef struct packed {
    logic                  dflt;  // default slave
    logic [num_slaves-1:0] slv;
  } slave_sel_t;

endpackage

//--- source/ahb_arbiter.sv
// fixed-priority bus arbiter with rotation mask; drives grant, master number and master lock
`timescale 1ns/1ps

module ahb_arbiter (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ahb_pkg::num_masters-1:0] busreq,   // bit 0 wins
  input  logic [ahb_pkg::num_masters-1:0] lock,
  input  logic                            hready,
  output logic [ahb_pkg::num_masters-1:0] grant,
  output logic [ahb_pkg::master_id_w-1:0] hmaster,
  output logic                            hmastlock
);
  import ahb_pkg::*;

  typedef enum logic {st_ready, st_stay} arb_state_e;

  arb_state_e             state;
  logic [num_masters-1:0] mask;        // set bit skips that master
  logic [num_masters-1:0] unmasked;
  logic [master_id_w-1:0] owner;
  logic                   owner_req;
  logic                   owner_lock;

  function automatic logic [num_masters-1:0] pick_lowest(input logic [num_masters-1:0] req);
    return req & (~req + num_masters'(1));
  endfunction

  function automatic logic [master_id_w-1:0] encode(input logic [num_masters-1:0] onehot);
    logic [master_id_w-1:0] idx;
    idx = '0;
    for (int i = num_masters - 1; i >= 0; i--) begin
      if (onehot[i]) begin
        idx = master_id_w'(i);
      end
    end
    return idx;
  endfunction

  assign owner     = encode(grant);
  assign owner_req = |(busreq & grant);
  assign unmasked  = busreq & ~mask;

  always_comb begin
    owner_lock = 1'b0;
    for (int i = 0; i < num_masters; i++) begin
      if (owner == master_id_w'(i)) begin
        owner_lock = lock[i];
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      grant     <= '0;
      hmaster   <= '0;
      hmastlock <= 1'b0;
      mask      <= '0;
      state     <= st_ready;
    end else if (hready) begin
      hmaster   <= owner;        // one accepted cycle behind grant
      hmastlock <= owner_lock;
      case (state)
        st_ready: begin
          if (|busreq) begin
            grant <= pick_lowest(busreq);
            mask  <= '0;
            state <= st_stay;
          end
        end
        st_stay: begin
          if (busreq == '0) begin
            grant <= '0;
            mask  <= '0;
            state <= st_ready;
          end else if (!owner_req) begin
            if (unmasked == '0) begin
              grant <= pick_lowest(busreq);  // everyone masked, start over
              mask  <= '0;
            end else begin
              grant <= pick_lowest(unmasked);
              mask  <= mask | grant;         // old owner waits its turn
            end
          end
        end
        default: begin
          grant <= '0;
          state <= st_ready;
        end
      endcase
    end
  end

endmodule

//--- source/ahb_master_mux.sv
// master-to-slave multiplexer; address phase by current master, write data by data-phase master
`timescale 1ns/1ps

module ahb_master_mux (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic                            hready,
  input  logic [ahb_pkg::master_id_w-1:0] hmaster,
  input  ahb_pkg::ahb_addr_t              m_addr  [ahb_pkg::num_masters],
  input  logic [ahb_pkg::data_w-1:0]      m_wdata [ahb_pkg::num_masters],
  output ahb_pkg::ahb_addr_t              addr,
  output logic [ahb_pkg::data_w-1:0]      wdata
);
  import ahb_pkg::*;

  logic [master_id_w-1:0] hmaster_q;  // owner of the data phase

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hmaster_q <= '0;
    end else if (hready) begin
      hmaster_q <= hmaster;
    end
  end

  // ----------------------------------------------------------------------
  // address phase, no latency
  // ----------------------------------------------------------------------
  always_comb begin
    addr = '0;                        // idle transfer for an unknown master
    for (int i = 0; i < num_masters; i++) begin
      if (hmaster == master_id_w'(i)) begin
        addr = m_addr[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // data phase
  // ----------------------------------------------------------------------
  always_comb begin
    wdata = '0;
    for (int i = 0; i < num_masters; i++) begin
      if (hmaster_q == master_id_w'(i)) begin
        wdata = m_wdata[i];
      end
    end
  end

endmodule

//--- source/ahb_decoder.sv
// address decoder; maps an address onto the slave selects, with remap swapping slaves 0 and 1
`timescale 1ns/1ps

module ahb_decoder (
  input  logic [ahb_pkg::addr_w-1:0]     haddr,
  input  logic                           remap,
  output logic [ahb_pkg::num_slaves-1:0] sel,
  output logic                           sel_default
);
  import ahb_pkg::*;

  logic [num_slaves-1:0] hit;

  always_comb begin
    for (int i = 0; i < num_slaves; i++) begin
      hit[i] = (haddr - slave_base[i]) < slave_size[i];  // no wrap at the top
    end
  end

  always_comb begin
    sel = hit;
    if (remap) begin
      sel[0] = hit[1];
      sel[1] = hit[0];
    end
  end

  assign sel_default = ~|hit;   // outside the map

endmodule

//--- source/ahb_response_mux.sv
// slave-to-master multiplexer; routes the response of the slave chosen in the last accepted phase
`timescale 1ns/1ps

module ahb_response_mux (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic [ahb_pkg::num_slaves-1:0] sel,
  input  logic                           sel_default,
  input  ahb_pkg::ahb_resp_t             s_resp [ahb_pkg::num_slaves],
  input  ahb_pkg::ahb_resp_t             dflt_resp,
  output ahb_pkg::ahb_resp_t             resp
);
  import ahb_pkg::*;

  slave_sel_t sel_d;
  slave_sel_t sel_q;   // data-phase select

  assign sel_d = {sel_default, sel};

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel_q <= '0;
    end else if (resp.hready) begin
      sel_q <= sel_d;
    end
  end

  // ----------------------------------------------------------------------
  // response routing
  // ----------------------------------------------------------------------
  always_comb begin
    resp.hrdata = '0;             // nothing selected answers okay
    resp.hresp  = resp_okay;
    resp.hready = 1'b1;
    if (sel_q.dflt) begin
      resp = dflt_resp;
    end
    for (int i = 0; i < num_slaves; i++) begin
      if (sel_q.slv[i]) begin
        resp = s_resp[i];
      end
    end
  end

endmodule

//--- source/ahb_default_slave.sv
// default slave; answers transfers outside the address map with a two-cycle error response
`timescale 1ns/1ps

module ahb_default_slave (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                sel,
  input  ahb_pkg::htrans_e    htrans,
  input  logic                hwrite,
  input  logic                hready,
  output ahb_pkg::ahb_resp_t  resp
);
  import ahb_pkg::*;

  typedef enum logic [1:0] {st_idle, st_write_err, st_read_err} dflt_state_e;

  dflt_state_e state;
  hresp_e      hresp_q;
  logic        hready_q;
  logic        start;

  // active transfer accepted this cycle
  assign start = sel && hready && (htrans == trans_nonseq || htrans == trans_seq);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state    <= st_idle;
      hresp_q  <= resp_okay;
      hready_q <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            hready_q <= 1'b0;       // first error cycle
            hresp_q  <= resp_error;
            state    <= hwrite ? st_write_err : st_read_err;
          end else begin
            hready_q <= 1'b1;
            hresp_q  <= resp_okay;
          end
        end
        st_write_err, st_read_err: begin
          hready_q <= 1'b1;         // second error cycle
          hresp_q  <= resp_error;
          state    <= st_idle;
        end
        default: begin
          hready_q <= 1'b1;
          hresp_q  <= resp_okay;
          state    <= st_idle;
        end
      endcase
    end
  end

  assign resp = '{hrdata: {data_w{1'b0}}, hresp: hresp_q, hready: hready_q};

endmodule

//--- source/ahb_bus_m3s3.sv
// three-master, three-slave AHB fabric top; connects arbiter, muxes, decoder and default slave
`timescale 1ns/1ps

module ahb_bus_m3s3 (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ahb_pkg::num_masters-1:0] m_busreq,
  input  logic [ahb_pkg::num_masters-1:0] m_lock,
  output logic [ahb_pkg::num_masters-1:0] m_grant,
  input  ahb_pkg::ahb_addr_t              m_addr  [ahb_pkg::num_masters],
  input  logic [ahb_pkg::data_w-1:0]      m_wdata [ahb_pkg::num_masters],
  output ahb_pkg::ahb_resp_t              m_resp,
  output ahb_pkg::ahb_addr_t              s_addr,
  output logic [ahb_pkg::data_w-1:0]      s_wdata,
  output logic                            s_hready,
  output logic [ahb_pkg::master_id_w-1:0] s_master,
  output logic                            s_mastlock,
  output logic [ahb_pkg::num_slaves-1:0]  s_sel,
  input  ahb_pkg::ahb_resp_t              s_resp  [ahb_pkg::num_slaves],
  input  logic                            remap
);
  import ahb_pkg::*;

  logic      hready;      // global ready from the response mux
  logic      sel_dflt;
  ahb_resp_t dflt_resp;

  assign hready   = m_resp.hready;
  assign s_hready = hready;

  // ----------------------------------------------------------------------
  // master side
  // ----------------------------------------------------------------------
  ahb_arbiter u_arbiter (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .busreq    (m_busreq),
    .lock      (m_lock),
    .hready    (hready),
    .grant     (m_grant),
    .hmaster   (s_master),
    .hmastlock (s_mastlock)
  );

  ahb_master_mux u_master_mux (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hready  (hready),
    .hmaster (s_master),
    .m_addr  (m_addr),
    .m_wdata (m_wdata),
    .addr    (s_addr),
    .wdata   (s_wdata)
  );

  // ----------------------------------------------------------------------
  // slave side
  // ----------------------------------------------------------------------
  ahb_decoder u_decoder (
    .haddr       (s_addr.haddr),
    .remap       (remap),
    .sel         (s_sel),
    .sel_default (sel_dflt)
  );

  ahb_response_mux u_response_mux (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .sel         (s_sel),
    .sel_default (sel_dflt),
    .s_resp      (s_resp),
    .dflt_resp   (dflt_resp),
    .resp        (m_resp)
  );

  ahb_default_slave u_default_slave (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .sel     (sel_dflt),
    .htrans  (s_addr.htrans),
    .hwrite  (s_addr.hwrite),
    .hready  (hready),
    .resp    (dflt_resp)
  );

endmodule

//--- tb/ahb_bus_properties.sv
// concurrent checks on the fabric top, attached to every ahb_bus_m3s3 by bind
`timescale 1ns/1ps

module ahb_bus_properties (
  input logic                            HCLK,
  input logic                            HRESETn,
  input logic [ahb_pkg::num_masters-1:0] grant,
  input logic [ahb_pkg::num_slaves-1:0]  sel,
  input ahb_pkg::ahb_resp_t              dflt_resp
);
  import ahb_pkg::*;

  grant_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(grant))
    else $error("grant is not one-hot or zero");

  sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(sel))
    else $error("slave select is not one-hot or zero");

  // wait state with error must lead into the ready error cycle
  dflt_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (!dflt_resp.hready && dflt_resp.hresp == resp_error)
      |=> (dflt_resp.hready && dflt_resp.hresp == resp_error))
    else $error("default slave error wait state not followed by a ready error cycle");

endmodule

bind ahb_bus_m3s3 ahb_bus_properties u_properties (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .grant     (m_grant),
  .sel       (s_sel),
  .dflt_resp (dflt_resp)
);

//--- tb/tb_ahb_bus.sv
// testbench for the AHB fabric; random masters and slaves checked against a cycle model
`timescale 1ns/1ps

module tb_ahb_bus;
  import ahb_pkg::*;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 16;
  localparam int test_cycles  = 500;
  localparam int num_tests    = 5;
  localparam int total_cycles = reset_cycles + num_tests * test_cycles + 1;

  logic                   HCLK;
  logic                   HRESETn;
  logic [num_masters-1:0] m_busreq;
  logic [num_masters-1:0] m_lock;
  logic [num_masters-1:0] m_grant;
  ahb_addr_t              m_addr  [num_masters];
  logic [data_w-1:0]      m_wdata [num_masters];
  ahb_resp_t              m_resp;
  ahb_addr_t              s_addr;
  logic [data_w-1:0]      s_wdata;
  logic                   s_hready;
  logic [master_id_w-1:0] s_master;
  logic                   s_mastlock;
  logic [num_slaves-1:0]  s_sel;
  ahb_resp_t              s_resp  [num_slaves];
  logic                   remap;

  // ----------------------------------------------------------------------
  // model of the fabric registers
  // ----------------------------------------------------------------------
  logic                   md_stay;      // arbiter holds an owner
  logic [num_masters-1:0] md_grant;
  logic [num_masters-1:0] md_mask;
  logic [master_id_w-1:0] md_master;
  logic                   md_mastlock;
  logic [master_id_w-1:0] md_master_q;  // data-phase master
  slave_sel_t             md_sel_q;
  logic                   md_dflt_busy;
  logic                   md_dflt_ready;
  hresp_e                 md_dflt_resp;
  int                     errors;
  int                     tests_bad;
  string                  test_name;

  ahb_bus_m3s3 dut0 (.*);

  initial begin
    HCLK = 1'b0;
    forever #(clk_period / 2) HCLK = ~HCLK;
  end

  initial begin
    #(total_cycles * clk_period * 2);
    $display("watchdog: the run did not end within %0d clock cycles", total_cycles * 2);
    $display("tests failed");
    $finish;
  end

  function automatic logic [num_masters-1:0] lowest_req(input logic [num_masters-1:0] req);
    for (int i = 0; i < num_masters; i++) begin
      if (req[i]) return num_masters'(1) << i;
    end
    return '0;
  endfunction

  function automatic logic [master_id_w-1:0] index_of(input logic [num_masters-1:0] onehot);
    for (int i = 0; i < num_masters; i++) begin
      if (onehot[i]) return master_id_w'(i);
    end
    return '0;
  endfunction

  // base <= addr < base + size, remap swaps slaves 0 and 1
  function automatic slave_sel_t decode(input logic [addr_w-1:0] a, input logic rm);
    logic [num_slaves-1:0] hit;
    for (int i = 0; i < num_slaves; i++) begin
      hit[i] = a >= slave_base[i] && {1'b0, a} < {1'b0, slave_base[i]} + {1'b0, slave_size[i]};
    end
    return '{dflt: ~|hit, slv: rm ? {hit[2], hit[0], hit[1]} : hit};
  endfunction

  function automatic logic [addr_w-1:0] pick_address(input int unmapped_pct);
    logic [1:0] k;
    k = 2'($urandom % num_slaves);
    if (int'($urandom % 100) >= unmapped_pct) return slave_base[k] + ($urandom % slave_size[k]);
    if ($urandom % 2 == 0) return slave_base[k] + slave_size[k] + ($urandom % 64);  // just past
    return $urandom;
  endfunction

  function automatic ahb_addr_t random_phase(input int unmapped_pct);
    ahb_addr_t p;
    p.haddr  = pick_address(unmapped_pct);
    p.htrans = htrans_e'(2'($urandom));
    {p.hwrite, p.hsize, p.hburst, p.hprot} = 11'($urandom);
    return p;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error %s: %s expected %h, actual %h at %0t", test_name, what, expected, actual,
             $time);
    errors++;
  endtask

  // ----------------------------------------------------------------------
  // stimulus, driven on the rising edge
  // ----------------------------------------------------------------------
  task automatic drive_inputs(input int mode);
    int          unmapped;
    logic [31:0] r;
    ahb_resp_t   sr;
    unmapped = (mode == 0) ? 0 : (mode == 2) ? 30 : (mode == 4) ? 70 : 10;
    r = $urandom;
    if (r[1:0] == 2'd0 || (mode == 0 && r[2])) m_busreq <= r[8 +: num_masters];
    m_lock <= r[12 +: num_masters];
    if (r[19:17] == 3'd0) remap <= ~remap;
    for (int i = 0; i < num_masters; i++) begin
      m_addr[i]  <= random_phase(unmapped);
      m_wdata[i] <= $urandom;
    end
    for (int i = 0; i < num_slaves; i++) begin
      r         = $urandom;
      sr.hrdata = $urandom;
      sr.hresp  = (mode == 4) ? resp_okay : hresp_e'(r[1:0]);  // only the default slave errs
      sr.hready = (mode == 0) || ((mode == 3) ? r[4:2] > 3'd3 : r[4:2] != 3'd0);
      s_resp[i] <= sr;
    end
  endtask

  // compare at the falling edge, then advance the model to the next rising edge
  task automatic check_and_step();
    ahb_addr_t              exp_addr;
    logic [data_w-1:0]      exp_wdata;
    slave_sel_t             exp_dec;
    ahb_resp_t              exp_resp;
    logic [num_masters-1:0] next_grant;
    exp_addr  = '0;
    exp_wdata = '0;
    for (int i = 0; i < num_masters; i++) begin
      if (md_master == master_id_w'(i)) exp_addr = m_addr[i];
      if (md_master_q == master_id_w'(i)) exp_wdata = m_wdata[i];
    end
    exp_dec  = decode(exp_addr.haddr, remap);
    exp_resp = '{hrdata: '0, hresp: resp_okay, hready: 1'b1};  // nothing selected
    if (md_sel_q.dflt) exp_resp = '{hrdata: '0, hresp: md_dflt_resp, hready: md_dflt_ready};
    for (int i = 0; i < num_slaves; i++) begin
      if (md_sel_q.slv[i]) exp_resp = s_resp[i];
    end

    assert (m_grant === md_grant) else report_mismatch("m_grant", 64'(md_grant), 64'(m_grant));
    assert (s_master === md_master) else report_mismatch("s_master", 64'(md_master), 64'(s_master));
    assert (s_mastlock === md_mastlock)
      else report_mismatch("s_mastlock", 64'(md_mastlock), 64'(s_mastlock));
    assert (s_addr === exp_addr) else report_mismatch("s_addr", 64'(exp_addr), 64'(s_addr));
    assert (s_wdata === exp_wdata) else report_mismatch("s_wdata", 64'(exp_wdata), 64'(s_wdata));
    assert (s_sel === exp_dec.slv) else report_mismatch("s_sel", 64'(exp_dec.slv), 64'(s_sel));
    assert (m_resp === exp_resp) else report_mismatch("m_resp", 64'(exp_resp), 64'(m_resp));
    assert (s_hready === exp_resp.hready)
      else report_mismatch("s_hready", 64'(exp_resp.hready), 64'(s_hready));

    if (md_dflt_busy) begin
      md_dflt_busy  = 1'b0;
      md_dflt_ready = 1'b1;  // second error cycle
      md_dflt_resp  = resp_error;
    end else begin
      md_dflt_busy  = exp_dec.dflt && exp_resp.hready &&
                      (exp_addr.htrans == trans_nonseq || exp_addr.htrans == trans_seq);
      md_dflt_ready = !md_dflt_busy;
      md_dflt_resp  = md_dflt_busy ? resp_error : resp_okay;
    end
    if (exp_resp.hready) begin
      md_sel_q    = exp_dec;
      md_master_q = md_master;
      md_master   = index_of(md_grant);
      for (int i = 0; i < num_masters; i++) begin
        if (md_master == master_id_w'(i)) md_mastlock = m_lock[i];
      end
      if (!md_stay || m_busreq == '0) begin
        md_grant = lowest_req(m_busreq);
        md_mask  = '0;
        md_stay  = m_busreq != '0;
      end else if ((m_busreq & md_grant) == '0) begin
        next_grant = lowest_req(m_busreq & ~md_mask);
        md_mask    = (next_grant == '0) ? '0 : md_mask | md_grant;  // owner waits its turn
        md_grant   = (next_grant == '0) ? lowest_req(m_busreq) : next_grant;
      end
    end
  endtask

  task automatic run_test(input string name, input int mode);
    int errors_before;
    int dflt_errs;
    errors_before = errors;
    dflt_errs     = 0;
    test_name     = name;
    repeat (test_cycles) begin
      @(posedge HCLK);
      drive_inputs(mode);
      @(negedge HCLK);
      check_and_step();
      if (m_resp.hresp == resp_error && !m_resp.hready) dflt_errs++;
    end
    assert (mode != 4 || dflt_errs > 0) else begin
      $display("%s: the default slave never gave an error response", name);
      errors++;
    end
    if (errors != errors_before) tests_bad++;
    $display("test %s: %s, %0d errors", name, (errors == errors_before) ? "PASS" : "FAIL",
             errors - errors_before);
  endtask

  initial begin
    void'($urandom(32'he9b8));
    errors    = 0;
    tests_bad = 0;
    HRESETn  <= 1'b0;
    m_busreq <= '0;
    m_lock   <= '0;
    remap    <= 1'b0;
    for (int i = 0; i < num_masters; i++) begin
      m_addr[i]  <= '0;
      m_wdata[i] <= '0;
    end
    for (int i = 0; i < num_slaves; i++) begin
      s_resp[i] <= '{hrdata: '0, hresp: resp_okay, hready: 1'b1};
    end
    md_stay       = 1'b0;
    md_grant      = '0;
    md_mask       = '0;
    md_master     = '0;
    md_mastlock   = 1'b0;
    md_master_q   = '0;
    md_sel_q      = '0;
    md_dflt_busy  = 1'b0;
    md_dflt_ready = 1'b1;
    md_dflt_resp  = resp_okay;
    repeat (reset_cycles) @(posedge HCLK);
    HRESETn <= 1'b1;
    test_name = "reset";
    @(negedge HCLK);
    check_and_step();
    run_test("arbitration", 0);
    run_test("master_mux", 1);
    run_test("decode_remap", 2);
    run_test("response_routing", 3);
    run_test("default_slave", 4);
    $display("tests run %0d, bad %0d, check errors %0d", num_tests, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- project.f
source/ahb_pkg.sv
source/ahb_arbiter.sv
source/ahb_master_mux.sv
source/ahb_decoder.sv
source/ahb_response_mux.sv
source/ahb_default_slave.sv
source/ahb_bus_m3s3.sv
tb/ahb_bus_properties.sv
tb/tb_ahb_bus.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
  verilator --binary --timing --assert -f project.f --top-module tb_ahb_bus -o tb_ahb_bus &&
  ./obj_dir/tb_ahb_bus > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0
